/* common/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// --------------------------------------------------
// line geometry
// --------------------------------------------------

// byte offset within a 32-byte line
`define DC_OFFSET_BITS 5

`define DC_INDEX_BITS 3

// whatever is left of the 32-bit address
`define DC_TAG_BITS 24

`define DC_LINE_BITS 256
`define DC_SETS 8

// --------------------------------------------------
// victim buffer
// --------------------------------------------------

// fully associative, one lru bit
`define DC_VICTIM_ENTRIES 2

`endif

/* common/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`DC_TAG_BITS-1:0] tag_t;

  typedef logic [`DC_INDEX_BITS-1:0] index_t;

  typedef logic [`DC_LINE_BITS-1:0] line_t;

  // tag and index name a line in the victim buffer
  typedef logic [`DC_TAG_BITS+`DC_INDEX_BITS-1:0] line_addr_t;

  // --------------------------------------------------
  // cpu address seen raw or split into fields
  // --------------------------------------------------
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      tag_t                       tag;
      index_t                     index;
      logic [`DC_OFFSET_BITS-1:0] offset;
    } f;
  } cache_addr_u;

endpackage

/* datacache/datacache_bus_adapter.sv */
`timescale 1ns/1ps

module datacache_bus_adapter (
  input  cache_pkg::cache_addr_u mem_address,
  input  logic [31:0]            mem_wdata,
  input  logic [3:0]             mem_byte_enable,
  input  cache_pkg::line_t       read_line,
  output cache_pkg::line_t       write_line,
  output logic [31:0]            byte_mask,
  output logic [31:0]            mem_rdata
);

  logic [2:0] word_sel;

  assign word_sel = mem_address.f.offset[4:2];  // word within the line

  // word copied to every slot and the mask picks the one that counts
  assign write_line = {8{mem_wdata}};
  assign byte_mask  = {28'b0, mem_byte_enable} << {word_sel, 2'b00};

  assign mem_rdata = read_line[{word_sel, 5'b00000} +: 32];

endmodule

/* datacache/datacache_control.sv */
`timescale 1ns/1ps

module datacache_control (
  input  logic clk,
  input  logic arst_n,
  input  logic mem_read,
  input  logic mem_write,
  input  logic hit,
  input  logic victim_hit,
  input  logic victim_evict_dirty,
  input  logic lru_way_valid,
  input  logic pmem_resp,
  output logic mem_resp,
  output logic pmem_read,
  output logic pmem_write,
  output logic load_line,
  output logic load_word,
  output logic set_dirty,
  output logic update_lru,
  output logic victim_swap,
  output logic victim_insert
);

  typedef enum logic [2:0] {
    st_idle,
    st_compare,
    st_swap,
    st_writeback,
    st_fill,
    st_respond
  } state_t;

  state_t state_q;
  state_t state_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // next state and strobes
  // --------------------------------------------------
  always_comb begin
    state_d       = state_q;
    mem_resp      = 1'b0;
    pmem_read     = 1'b0;
    pmem_write    = 1'b0;
    load_line     = 1'b0;
    load_word     = 1'b0;
    set_dirty     = 1'b0;
    update_lru    = 1'b0;
    victim_swap   = 1'b0;
    victim_insert = 1'b0;

    case (state_q)
      st_idle: begin
        if (mem_read || mem_write) begin
          state_d = st_compare;
        end
      end
      st_compare: begin
        if (hit) begin
          mem_resp   = 1'b1;
          load_word  = mem_write;  // store merges on the closing edge
          set_dirty  = mem_write;
          update_lru = 1'b1;
          state_d    = st_idle;
        end else if (victim_hit) begin
          state_d = st_swap;
        end else if (lru_way_valid && victim_evict_dirty) begin
          state_d = st_writeback;  // make room in the victim buffer first
        end else begin
          victim_insert = lru_way_valid;  // nothing to keep from an empty way
          state_d       = st_fill;
        end
      end
      st_swap: begin
        victim_swap = 1'b1;
        load_line   = 1'b1;
        state_d     = st_respond;
      end
      st_writeback: begin
        pmem_write = 1'b1;
        if (pmem_resp) begin
          victim_insert = 1'b1;
          state_d       = st_fill;
        end
      end
      st_fill: begin
        pmem_read = 1'b1;
        if (pmem_resp) begin
          load_line = 1'b1;  // fresh line arrives clean
          state_d   = st_respond;
        end
      end
      st_respond: begin
        mem_resp   = 1'b1;
        load_word  = mem_write;
        set_dirty  = mem_write;
        update_lru = 1'b1;
        state_d    = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

endmodule

/* datacache/datacache_datapath.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module datacache_datapath (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cache_pkg::cache_addr_u mem_address,
  input  cache_pkg::line_t       line_in,
  input  cache_pkg::line_t       write_line,
  input  logic [31:0]            byte_mask,
  input  logic                   load_line,
  input  logic                   load_word,
  input  logic                   set_dirty,
  input  logic                   update_lru,
  output logic                   hit,
  output logic                   hit_way,
  output logic                   lru_way_valid,
  output cache_pkg::line_t       evict_line,
  output cache_pkg::line_addr_t  evict_addr,
  output logic                   evict_dirty,
  output cache_pkg::line_t       read_line
);

  cache_pkg::tag_t  tag_q  [2][`DC_SETS];
  cache_pkg::line_t data_q [2][`DC_SETS];

  logic [1:0][`DC_SETS-1:0] valid_q;
  logic [1:0][`DC_SETS-1:0] dirty_q;
  logic [`DC_SETS-1:0]      lru_q;  // way to replace next

  cache_pkg::index_t idx;
  cache_pkg::tag_t   tag;
  logic [1:0]        way_match;
  logic              lru_way;
  cache_pkg::line_t  merged_line;

  assign idx     = mem_address.f.index;
  assign tag     = mem_address.f.tag;
  assign lru_way = lru_q[idx];

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_match[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
    end
  end

  assign hit       = |way_match;
  assign hit_way   = way_match[1];
  assign read_line = data_q[hit_way][idx];

  // eviction candidate
  assign lru_way_valid = valid_q[lru_way][idx];
  assign evict_dirty   = dirty_q[lru_way][idx];
  assign evict_line    = data_q[lru_way][idx];
  assign evict_addr    = {tag_q[lru_way][idx], idx};

  // byte merge of a store into the hit line
  always_comb begin
    for (int b = 0; b < `DC_LINE_BITS/8; b++) begin
      merged_line[8*b +: 8] = byte_mask[b] ? write_line[8*b +: 8] : read_line[8*b +: 8];
    end
  end

  // --------------------------------------------------
  // arrays
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_line) begin
      data_q[lru_way][idx] <= line_in;
      tag_q[lru_way][idx]  <= tag;
    end else if (load_word) begin
      data_q[hit_way][idx] <= merged_line;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (load_line) begin
        valid_q[lru_way][idx] <= 1'b1;
        dirty_q[lru_way][idx] <= set_dirty;  // from the incoming line
      end else if (load_word && set_dirty) begin
        dirty_q[hit_way][idx] <= 1'b1;
      end
      if (update_lru) begin
        lru_q[idx] <= ~hit_way;
      end
    end
  end

endmodule

/* datacache/datacache_victim.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module datacache_victim (
  input  logic                  clk,
  input  logic                  arst_n,
  input  cache_pkg::line_addr_t lookup_addr,
  input  cache_pkg::line_t      insert_line,
  input  cache_pkg::line_addr_t insert_addr,
  input  logic                  insert_dirty,
  input  logic                  insert_valid,
  input  logic                  victim_swap,
  input  logic                  victim_insert,
  output logic                  victim_hit,
  output cache_pkg::line_t      victim_line,
  output logic                  victim_dirty_hit,
  output logic                  evict_dirty,
  output cache_pkg::line_addr_t wb_addr,
  output cache_pkg::line_t      wb_line
);

  cache_pkg::line_addr_t addr_q [`DC_VICTIM_ENTRIES];
  cache_pkg::line_t      line_q [`DC_VICTIM_ENTRIES];

  logic [`DC_VICTIM_ENTRIES-1:0] valid_q;
  logic [`DC_VICTIM_ENTRIES-1:0] dirty_q;
  logic                          lru_q;  // entry to overwrite next

  logic [`DC_VICTIM_ENTRIES-1:0] entry_match;
  logic                          hit_entry;
  logic                          wr_entry;

  always_comb begin
    for (int e = 0; e < `DC_VICTIM_ENTRIES; e++) begin
      entry_match[e] = valid_q[e] && (addr_q[e] == lookup_addr);
    end
  end

  assign victim_hit       = |entry_match;
  assign hit_entry        = entry_match[1];
  assign victim_line      = line_q[hit_entry];
  assign victim_dirty_hit = dirty_q[hit_entry];

  // lru entry goes to memory if dirty
  assign evict_dirty = valid_q[lru_q] & dirty_q[lru_q];
  assign wb_addr     = addr_q[lru_q];
  assign wb_line     = line_q[lru_q];

  assign wr_entry = victim_swap ? hit_entry : lru_q;

  // --------------------------------------------------
  // entry update
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (victim_swap || victim_insert) begin
      addr_q[wr_entry] <= insert_addr;
      line_q[wr_entry] <= insert_line;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= 1'b0;
    end else if (victim_swap || victim_insert) begin
      valid_q[wr_entry] <= insert_valid;
      dirty_q[wr_entry] <= insert_dirty & insert_valid;
      lru_q             <= ~wr_entry;  // newest entry stays longest
    end
  end

endmodule

/* datacache/datacache.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module datacache (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [31:0]         mem_address,
  input  logic [31:0]         mem_wdata,
  input  logic [3:0]          mem_byte_enable,
  input  logic                mem_read,
  input  logic                mem_write,
  output logic [31:0]         mem_rdata,
  output logic                mem_resp,
  input  logic                pmem_resp,
  input  cache_pkg::line_t    pmem_rdata,
  output logic [31:0]         pmem_address,
  output cache_pkg::line_t    pmem_wdata,
  output logic                pmem_read,
  output logic                pmem_write
);

  cache_pkg::cache_addr_u req_addr;
  cache_pkg::line_addr_t  req_line_addr;

  logic                  hit;
  logic                  lru_way_valid;
  logic                  dp_evict_dirty;
  cache_pkg::line_t      evict_line;
  cache_pkg::line_addr_t evict_addr;
  cache_pkg::line_t      read_line;
  cache_pkg::line_t      line_in;
  logic                  line_dirty;

  logic                  victim_hit;
  logic                  victim_dirty_hit;
  logic                  vb_evict_dirty;
  cache_pkg::line_t      victim_line;
  cache_pkg::line_addr_t wb_addr;

  logic                  load_line;
  logic                  load_word;
  logic                  set_dirty;
  logic                  update_lru;
  logic                  victim_swap;
  logic                  victim_insert;

  cache_pkg::line_t      write_line;
  logic [31:0]           byte_mask;

  assign req_addr      = mem_address;
  assign req_line_addr = {req_addr.f.tag, req_addr.f.index};

  // --------------------------------------------------
  // memory address and incoming line
  // --------------------------------------------------
  assign pmem_address = pmem_write ? {wb_addr, {`DC_OFFSET_BITS{1'b0}}}
                                   : {req_line_addr, {`DC_OFFSET_BITS{1'b0}}};
  assign line_in      = pmem_resp ? pmem_rdata : victim_line;  // fill or swap

  // a swapped-in line keeps its own dirty bit
  assign line_dirty = set_dirty | (victim_swap & victim_dirty_hit);

  datacache_control i_control (
    .clk                (clk),
    .arst_n             (arst_n),
    .mem_read           (mem_read),
    .mem_write          (mem_write),
    .hit                (hit),
    .victim_hit         (victim_hit),
    .victim_evict_dirty (vb_evict_dirty),
    .lru_way_valid      (lru_way_valid),
    .pmem_resp          (pmem_resp),
    .mem_resp           (mem_resp),
    .pmem_read          (pmem_read),
    .pmem_write         (pmem_write),
    .load_line          (load_line),
    .load_word          (load_word),
    .set_dirty          (set_dirty),
    .update_lru         (update_lru),
    .victim_swap        (victim_swap),
    .victim_insert      (victim_insert)
  );

  datacache_datapath i_datapath (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_address   (req_addr),
    .line_in       (line_in),
    .write_line    (write_line),
    .byte_mask     (byte_mask),
    .load_line     (load_line),
    .load_word     (load_word),
    .set_dirty     (line_dirty),
    .update_lru    (update_lru),
    .hit           (hit),
    .hit_way       (),
    .lru_way_valid (lru_way_valid),
    .evict_line    (evict_line),
    .evict_addr    (evict_addr),
    .evict_dirty   (dp_evict_dirty),
    .read_line     (read_line)
  );

  datacache_victim i_victim (
    .clk              (clk),
    .arst_n           (arst_n),
    .lookup_addr      (req_line_addr),
    .insert_line      (evict_line),
    .insert_addr      (evict_addr),
    .insert_dirty     (dp_evict_dirty),
    .insert_valid     (lru_way_valid),
    .victim_swap      (victim_swap),
    .victim_insert    (victim_insert),
    .victim_hit       (victim_hit),
    .victim_line      (victim_line),
    .victim_dirty_hit (victim_dirty_hit),
    .evict_dirty      (vb_evict_dirty),
    .wb_addr          (wb_addr),
    .wb_line          (pmem_wdata)
  );

  datacache_bus_adapter i_bus_adapter (
    .mem_address     (req_addr),
    .mem_wdata       (mem_wdata),
    .mem_byte_enable (mem_byte_enable),
    .read_line       (read_line),
    .write_line      (write_line),
    .byte_mask       (byte_mask),
    .mem_rdata       (mem_rdata)
  );

endmodule

/* tb/pmem_model.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module pmem_model (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [31:0]              pmem_address,
  input  logic [`DC_LINE_BITS-1:0] pmem_wdata,
  input  logic                     pmem_read,
  input  logic                     pmem_write,
  output logic                     pmem_resp,
  output logic [`DC_LINE_BITS-1:0] pmem_rdata,
  output int                       read_count,
  output int                       write_count
);

  localparam int WORDS   = 1024;  // 4 KB of backing store
  localparam int LATENCY = 4;

  logic [31:0] mem [WORDS];
  logic [9:0]  base;
  int          wait_cnt;

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (i * 4) ^ 32'h6145_0000;
    end
  end

  assign base = {pmem_address[11:5], 3'b000};  // first word of the line

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pmem_resp   <= 1'b0;
      pmem_rdata  <= '0;
      wait_cnt    <= 0;
      read_count  <= 0;
      write_count <= 0;
    end else begin
      pmem_resp <= 1'b0;
      if ((pmem_read || pmem_write) && !pmem_resp) begin
        if (wait_cnt == LATENCY - 1) begin
          wait_cnt  <= 0;
          pmem_resp <= 1'b1;
          if (pmem_read) begin
            for (int w = 0; w < 8; w++) begin
              pmem_rdata[32*w +: 32] <= mem[base + w];
            end
            read_count <= read_count + 1;
          end else begin
            for (int w = 0; w < 8; w++) begin
              mem[base + w] <= pmem_wdata[32*w +: 32];
            end
            write_count <= write_count + 1;
          end
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end else begin
        wait_cnt <= 0;  // idle or response cycle
      end
    end
  end

endmodule

/* tb/tb_datacache.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_datacache;

  localparam int N_OPS = 22;

  logic clk;
  logic arst_n;
  logic [31:0] mem_address;
  logic [31:0] mem_wdata;
  logic [3:0] mem_byte_enable;
  logic mem_read;
  logic mem_write;
  logic [31:0] mem_rdata;
  logic mem_resp;
  logic pmem_resp;
  logic [`DC_LINE_BITS-1:0] pmem_rdata;
  logic [`DC_LINE_BITS-1:0] pmem_wdata;
  logic [31:0] pmem_address;
  logic pmem_read;
  logic pmem_write;
  int read_count;
  int write_count;

  // stimulus table
  string       op_name  [N_OPS];
  logic        op_write [N_OPS];
  logic [31:0] op_addr  [N_OPS];
  logic [31:0] op_wdata [N_OPS];
  logic [3:0]  op_be    [N_OPS];
  int          op_reads [N_OPS];
  int          op_wbs   [N_OPS];
  int          op_edges [N_OPS];  // 0 when latency varies

  logic [7:0] shadow [0:4095];
  integer     seed = 32'h6145;
  int         n_ops = 0;
  int         checks = 0;
  int         errors = 0;
  int         tests_failed = 0;
  string      cur_test = "reset_idle";

  datacache i_datacache (
    .clk(clk), .arst_n(arst_n),
    .mem_address(mem_address), .mem_wdata(mem_wdata),
    .mem_byte_enable(mem_byte_enable), .mem_read(mem_read), .mem_write(mem_write),
    .mem_rdata(mem_rdata), .mem_resp(mem_resp),
    .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata), .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata), .pmem_read(pmem_read), .pmem_write(pmem_write)
  );

  pmem_model i_pmem_model (
    .clk(clk), .arst_n(arst_n), .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
    .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata), .read_count(read_count), .write_count(write_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h6145_0000;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    return {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h", what, expected, actual);
    end
  endtask

  task automatic add_op(input string name, input logic wr, input logic [31:0] addr,
                        input logic [3:0] be, input int rd, input int wb, input int edges);
    op_name[n_ops]  = name;
    op_write[n_ops] = wr;
    op_addr[n_ops]  = addr;
    op_wdata[n_ops] = wr ? $random(seed) : 32'h0;
    op_be[n_ops]    = be;
    op_reads[n_ops] = rd;
    op_wbs[n_ops]   = wb;
    op_edges[n_ops] = edges;
    n_ops++;
  endtask

  // lines a to h share set 0 and word selection uses set 1
  task automatic build_table();
    add_op("cold_read_a",    0, 32'h004, 4'hf,   1, 0, 0);
    add_op("write_a_part",   1, 32'h008, 4'b0101, 0, 0, 2);
    add_op("read_a_merged",  0, 32'h008, 4'hf,   0, 0, 2);
    add_op("cold_read_b",    0, 32'h104, 4'hf,   1, 0, 0);
    add_op("read_c_evict_a", 0, 32'h200, 4'hf,   1, 0, 0);
    add_op("read_d_evict_b", 0, 32'h310, 4'hf,   1, 0, 0);
    add_op("victim_hit_a",   0, 32'h008, 4'hf,   0, 0, 4);  // one swap cycle
    add_op("write_d_full",   1, 32'h310, 4'hf,   0, 0, 2);
    add_op("read_e",         0, 32'h400, 4'hf,   1, 0, 0);
    add_op("read_f",         0, 32'h500, 4'hf,   1, 0, 0);
    add_op("read_g_wb_a",    0, 32'h600, 4'hf,   1, 1, 0);
    add_op("read_h_wb_d",    0, 32'h700, 4'hf,   1, 1, 0);
    add_op("refill_a",       0, 32'h008, 4'hf,   1, 0, 0);
    add_op("refill_d",       0, 32'h310, 4'hf,   1, 0, 0);
    add_op("word_sel_7",     0, 32'h03c, 4'hf,   1, 0, 0);
    for (int k = 0; k < 7; k++) begin
      add_op($sformatf("word_sel_%0d", k), 0, 32'h020 + 4 * k, 4'hf, 0, 0, 2);
    end
  endtask

  task automatic run_op(input int i);
    int rd_start;
    int wb_start;
    int edges;
    int err_start;
    err_start = errors;
    cur_test  = op_name[i];
    @(posedge clk);
    rd_start = read_count;
    wb_start = write_count;
    mem_address     <= op_addr[i];
    mem_wdata       <= op_wdata[i];
    mem_byte_enable <= op_be[i];
    mem_read        <= !op_write[i];
    mem_write       <= op_write[i];
    @(negedge clk);
    edges = 1;
    while (mem_resp !== 1'b1) begin
      @(negedge clk);
      edges++;
    end
    if (op_edges[i] != 0) begin
      check_value({op_name[i], " latency"}, op_edges[i], edges);
    end
    check_value({op_name[i], " pmem reads"}, op_reads[i], read_count - rd_start);
    check_value({op_name[i], " pmem writes"}, op_wbs[i], write_count - wb_start);
    if (op_write[i]) begin
      for (int b = 0; b < 4; b++) begin
        if (op_be[i][b]) begin
          shadow[op_addr[i] + b] = op_wdata[i][8*b +: 8];
        end
      end
    end else begin
      check_value({op_name[i], " rdata"}, shadow_word(op_addr[i]), mem_rdata);
    end
    @(posedge clk);
    mem_read  <= 1'b0;
    mem_write <= 1'b0;
    if (errors == err_start) begin
      $display("%s: ok", op_name[i]);
    end else begin
      tests_failed++;
      $display("%s: failed", op_name[i]);
    end
  endtask

  // memory port address and writeback contents
  always @(negedge clk) begin
    if (pmem_read) begin
      check_value({cur_test, " fill address"}, {mem_address[31:5], 5'b00000}, pmem_address);
    end
    if (pmem_write) begin
      check_value({cur_test, " writeback alignment"}, 32'h0, {27'b0, pmem_address[4:0]});
      for (int w = 0; w < 8; w++) begin
        check_value({cur_test, " writeback data"}, shadow_word(pmem_address + 4 * w),
                    pmem_wdata[32*w +: 32]);  // line as the cpu left it
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] word;
    int          err_start;
    arst_n          = 1'b0;
    mem_address     = '0;
    mem_wdata       = '0;
    mem_byte_enable = '0;
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    build_table();
    for (int a = 0; a < 4096; a++) begin
      word      = pattern_word(a);
      shadow[a] = word[8*(a & 3) +: 8];
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    err_start = errors;
    repeat (3) begin
      @(negedge clk);
      check_value("reset_idle mem_resp", 0, mem_resp);
      check_value("reset_idle pmem_read", 0, pmem_read);
      check_value("reset_idle pmem_write", 0, pmem_write);
    end
    if (errors == err_start) begin
      $display("reset_idle: ok");
    end else begin
      tests_failed++;
      $display("reset_idle: failed");
    end
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_ops + 1, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (N_OPS * 200) @(posedge clk);
    $display("timeout, the cache stopped answering requests");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/cache_pkg.sv
datacache/datacache_bus_adapter.sv
datacache/datacache_control.sv
datacache/datacache_datapath.sv
datacache/datacache_victim.sv
datacache/datacache.sv
tb/pmem_model.sv
tb/tb_datacache.sv

/* Bender.yml */
package:
  name: datacache

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - datacache/datacache_bus_adapter.sv
      - datacache/datacache_control.sv
      - datacache/datacache_datapath.sv
      - datacache/datacache_victim.sv
      - datacache/datacache.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/pmem_model.sv
      - tb/tb_datacache.sv
